//--- design/rr_defs_config.svh
`ifndef RR_DEFS_CONFIG_SVH
`define RR_DEFS_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// data path widths
////////////////////////////////////////////////////////////////////////////
// payload carried on the shell, replay and cl streams
`define RR_DATA_W 32
// recording sequence number, wraps around
`define RR_SEQ_W 8
// entries held by the log fifo before new entries are dropped
`define RR_LOG_DEPTH 4

////////////////////////////////////////////////////////////////////////////
// configuration port
////////////////////////////////////////////////////////////////////////////
`define RR_CFG_ADDR_W 8
`define RR_CFG_DATA_W 32
// mode register, wdata[0] is record enable and wdata[1] is replay enable
`define RR_ADDR_MODE 8'h00
// any write here clears the sticky overflow status
`define RR_ADDR_CLEAR 8'h04

`endif

//--- design/rr_bus_pkg.sv
`include "rr_defs_config.svh"

// types that travel on the data side of the wrapper
package rr_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // channel payload and log word
  ////////////////////////////////////////////////////////////////////////////

  // one beat on the shell, replay or cl stream
  typedef logic [`RR_DATA_W-1:0] rr_data_t;

  // order tag of a recorded transfer
  // restarts at 0 each time record is switched on
  typedef logic [`RR_SEQ_W-1:0] rr_seq_t;

  // width of a full log word
  localparam int RR_LOG_ENTRY_W = `RR_SEQ_W + `RR_DATA_W;

  // log word layout
  //   upper RR_SEQ_W bits  -> sequence number
  //   lower RR_DATA_W bits -> recorded data
  typedef logic [RR_LOG_ENTRY_W-1:0] rr_log_entry_t;

endpackage

//--- design/rr_ctrl_pkg.sv
`include "rr_defs_config.svh"

// types used on the configuration and control side
package rr_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // configuration write port
  ////////////////////////////////////////////////////////////////////////////

  // byte address of a csr
  typedef logic [`RR_CFG_ADDR_W-1:0] rr_cfg_addr_t;

  // write data, only the low bits matter for the mode register
  typedef logic [`RR_CFG_DATA_W-1:0] rr_cfg_data_t;

  ////////////////////////////////////////////////////////////////////////////
  // operating mode
  ////////////////////////////////////////////////////////////////////////////

  // encoding matches the mode register bits
  //   bit 0 -> record enable
  //   bit 1 -> replay enable
  typedef enum logic [1:0] {
    RR_PASS          = 2'b00,
    RR_RECORD        = 2'b01,
    RR_REPLAY        = 2'b10,
    RR_REPLAY_RECORD = 2'b11
  } rr_mode_e;

endpackage

//--- design/rr_csr_decode.sv
`timescale 1ns/1ps
`include "rr_defs_config.svh"

module rr_csr_decode (
  input  logic                     clk,
  input  logic                     rstn,
  // host configuration writes, accepted every cycle
  input  logic                     i_cfg_valid,
  input  rr_ctrl_pkg::rr_cfg_addr_t i_cfg_addr,
  input  rr_ctrl_pkg::rr_cfg_data_t i_cfg_wdata,
  // one-cycle pulse from the log fifo when an entry is lost
  input  logic                     i_drop,
  output rr_ctrl_pkg::rr_mode_e    o_mode,
  output logic                     o_ovf
);

  import rr_ctrl_pkg::*;

  rr_mode_e mode_q;
  logic     ovf_q;
  logic     mode_wr;
  logic     clear_wr;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////
  // anything other than these two addresses is ignored
  assign mode_wr  = i_cfg_valid && (i_cfg_addr == `RR_ADDR_MODE);
  assign clear_wr = i_cfg_valid && (i_cfg_addr == `RR_ADDR_CLEAR);

  // mode register, new mode is seen by the channel select next cycle
  always_ff @(posedge clk) begin
    if (!rstn) begin
      mode_q <= RR_PASS;
    end else if (mode_wr) begin
      // low two bits map straight onto the enum encoding
      mode_q <= rr_mode_e'(i_cfg_wdata[1:0]);
    end
  end

  // sticky overflow
  // a drop in the same cycle as a clear keeps the bit set
  always_ff @(posedge clk) begin
    if (!rstn) begin
      ovf_q <= 1'b0;
    end else if (i_drop) begin
      ovf_q <= 1'b1;
    end else if (clear_wr) begin
      ovf_q <= 1'b0;
    end
  end

  assign o_mode = mode_q;
  assign o_ovf  = ovf_q;

  // mode stays a known, legal encoding out of reset
  a_mode_legal : assert property (@(posedge clk) disable iff (!rstn)
    !$isunknown(o_mode) &&
    (o_mode inside {RR_PASS, RR_RECORD, RR_REPLAY, RR_REPLAY_RECORD}));

endmodule

//--- design/rr_channel_select.sv
`timescale 1ns/1ps

module rr_channel_select (
  input  logic                        clk,
  input  logic                        rstn,
  input  rr_ctrl_pkg::rr_mode_e       i_mode,
  // shell source
  input  logic                        i_sh_valid,
  input  rr_bus_pkg::rr_data_t        i_sh_data,
  output logic                        o_sh_ready,
  // replay source
  input  logic                        i_rply_valid,
  input  rr_bus_pkg::rr_data_t        i_rply_data,
  output logic                        o_rply_ready,
  // cl sink
  output logic                        o_cl_valid,
  output rr_bus_pkg::rr_data_t        o_cl_data,
  input  logic                        i_cl_ready,
  // numbered entries toward the log fifo
  output logic                        o_rec_valid,
  output rr_bus_pkg::rr_log_entry_t   o_rec_entry
);

  import rr_bus_pkg::*;
  import rr_ctrl_pkg::*;

  logic    replay_en;
  logic    record_en;
  logic    cl_xfer;
  rr_seq_t seq_q;

  ////////////////////////////////////////////////////////////////////////////
  // mode bits
  ////////////////////////////////////////////////////////////////////////////
  assign replay_en = (i_mode == RR_REPLAY) || (i_mode == RR_REPLAY_RECORD);
  assign record_en = (i_mode == RR_RECORD) || (i_mode == RR_REPLAY_RECORD);

  ////////////////////////////////////////////////////////////////////////////
  // source mux
  ////////////////////////////////////////////////////////////////////////////
  // purely combinational, no added latency toward the cl
  // the source that is not selected sees ready low and simply waits
  assign o_cl_valid   = replay_en ? i_rply_valid : i_sh_valid;
  assign o_cl_data    = replay_en ? i_rply_data  : i_sh_data;
  assign o_sh_ready   = !replay_en && i_cl_ready;
  assign o_rply_ready =  replay_en && i_cl_ready;

  // handshake on the cl side, this is what gets recorded
  assign cl_xfer = o_cl_valid && i_cl_ready;

  ////////////////////////////////////////////////////////////////////////////
  // recording
  ////////////////////////////////////////////////////////////////////////////
  // whichever source feeds the cl is the one logged,
  // so record during replay logs the replayed words
  assign o_rec_valid = record_en && cl_xfer;
  assign o_rec_entry = {seq_q, o_cl_data};

  // sequence counter
  // parked at 0 while record is off, so turning record on starts at 0
  // a mode write that keeps record on leaves it running
  // advances on every recorded beat, dropped ones too, so gaps show losses
  always_ff @(posedge clk) begin
    if (!rstn) begin
      seq_q <= '0;
    end else if (!record_en) begin
      seq_q <= '0;
    end else if (cl_xfer) begin
      seq_q <= seq_q + 1'b1;
    end
  end

  // only one source may be granted at a time
  a_one_ready : assert property (@(posedge clk) disable iff (!rstn)
    !(o_sh_ready && o_rply_ready));

endmodule

//--- design/rr_log_writeback.sv
`timescale 1ns/1ps
`include "rr_defs_config.svh"

module rr_log_writeback (
  input  logic                      clk,
  input  logic                      rstn,
  // entries from the channel select, never back-pressured
  input  logic                      i_rec_valid,
  input  rr_bus_pkg::rr_log_entry_t i_rec_entry,
  // log drain stream
  output logic                      o_log_valid,
  output rr_bus_pkg::rr_log_entry_t o_log_data,
  input  logic                      i_log_ready,
  // push hit a full fifo, entry lost
  output logic                      o_drop
);

  import rr_bus_pkg::*;

  localparam int DEPTH = `RR_LOG_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // storage, contents only matter where count says they are valid
  rr_log_entry_t    mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;
  logic             pop;

  ////////////////////////////////////////////////////////////////////////////
  // fifo control
  ////////////////////////////////////////////////////////////////////////////
  assign full = (count == CNT_W'(DEPTH));
  assign pop  = o_log_valid && i_log_ready;

  // a full fifo refuses the push even if it is popped in the same cycle,
  // older entries are never overwritten
  assign push   = i_rec_valid && !full;
  assign o_drop = i_rec_valid && full;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the count unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // entry written at edge N, visible on the output after that edge
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_rec_entry;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output stream
  ////////////////////////////////////////////////////////////////////////////
  assign o_log_valid = (count != '0);
  assign o_log_data  = mem[rd_ptr];

  // a stalled head entry must not change under the consumer
  a_log_hold : assert property (@(posedge clk) disable iff (!rstn)
    o_log_valid && !i_log_ready |=> o_log_valid && $stable(o_log_data));

  // occupancy bound
  a_count_max : assert property (@(posedge clk) disable iff (!rstn)
    count <= CNT_W'(DEPTH));

endmodule

//--- design/rr_wrapper.sv
`timescale 1ns/1ps

module rr_wrapper (
  input  logic                      clk,
  input  logic                      rstn,
  // configuration writes from the host
  input  logic                      i_cfg_valid,
  input  rr_ctrl_pkg::rr_cfg_addr_t i_cfg_addr,
  input  rr_ctrl_pkg::rr_cfg_data_t i_cfg_wdata,
  // shell stream in
  input  logic                      i_sh_valid,
  input  rr_bus_pkg::rr_data_t      i_sh_data,
  output logic                      o_sh_ready,
  // replay stream in
  input  logic                      i_rply_valid,
  input  rr_bus_pkg::rr_data_t      i_rply_data,
  output logic                      o_rply_ready,
  // cl stream out
  output logic                      o_cl_valid,
  output rr_bus_pkg::rr_data_t      o_cl_data,
  input  logic                      i_cl_ready,
  // log stream out
  output logic                      o_log_valid,
  output rr_bus_pkg::rr_log_entry_t o_log_data,
  input  logic                      i_log_ready,
  // sticky overflow status
  output logic                      o_ovf
);

  import rr_bus_pkg::*;
  import rr_ctrl_pkg::*;

  // csr block -> channel select
  rr_mode_e      mode;
  // channel select -> log fifo
  logic          rec_valid;
  rr_log_entry_t rec_entry;
  // log fifo -> csr block
  logic          drop;

  ////////////////////////////////////////////////////////////////////////////
  // configuration and status
  ////////////////////////////////////////////////////////////////////////////
  rr_csr_decode u_csr (
    .clk         (clk),
    .rstn        (rstn),
    .i_cfg_valid (i_cfg_valid),
    .i_cfg_addr  (i_cfg_addr),
    .i_cfg_wdata (i_cfg_wdata),
    .i_drop      (drop),
    .o_mode      (mode),
    .o_ovf       (o_ovf)
  );

  ////////////////////////////////////////////////////////////////////////////
  // shell / replay select and recording tap
  ////////////////////////////////////////////////////////////////////////////
  rr_channel_select u_sel (
    .clk          (clk),
    .rstn         (rstn),
    .i_mode       (mode),
    .i_sh_valid   (i_sh_valid),
    .i_sh_data    (i_sh_data),
    .o_sh_ready   (o_sh_ready),
    .i_rply_valid (i_rply_valid),
    .i_rply_data  (i_rply_data),
    .o_rply_ready (o_rply_ready),
    .o_cl_valid   (o_cl_valid),
    .o_cl_data    (o_cl_data),
    .i_cl_ready   (i_cl_ready),
    .o_rec_valid  (rec_valid),
    .o_rec_entry  (rec_entry)
  );

  ////////////////////////////////////////////////////////////////////////////
  // log buffering
  ////////////////////////////////////////////////////////////////////////////
  rr_log_writeback u_wb (
    .clk         (clk),
    .rstn        (rstn),
    .i_rec_valid (rec_valid),
    .i_rec_entry (rec_entry),
    .o_log_valid (o_log_valid),
    .o_log_data  (o_log_data),
    .i_log_ready (i_log_ready),
    .o_drop      (drop)
  );

endmodule

//--- tests/tb_rr_wrapper.sv
`timescale 1ns/1ps
`include "rr_defs_config.svh"

module tb_rr_wrapper;

  import rr_bus_pkg::*;
  import rr_ctrl_pkg::*;

  // cycles any single wait may spend before giving up
  localparam int TIMEOUT = 200;

  logic          clk;
  logic          rstn;
  logic          i_cfg_valid;
  rr_cfg_addr_t  i_cfg_addr;
  rr_cfg_data_t  i_cfg_wdata;
  logic          i_sh_valid;
  rr_data_t      i_sh_data;
  logic          o_sh_ready;
  logic          i_rply_valid;
  rr_data_t      i_rply_data;
  logic          o_rply_ready;
  logic          o_cl_valid;
  rr_data_t      o_cl_data;
  logic          i_cl_ready;
  logic          o_log_valid;
  rr_log_entry_t o_log_data;
  logic          i_log_ready;
  logic          o_ovf;

  // ready control
  // log ready is held low for 0, held high for 1 and random for 2
  logic          cl_ready_rand;
  int            log_ready_sel;
  logic [31:0]   ready_rnd;

  // filled by the monitor only and read by index in the tests
  rr_data_t      cl_q[$];
  rr_log_entry_t log_q[$];
  int            log_valid_cnt = 0;
  int            sh_ready_cnt  = 0;

  int            log_rd    = 0;
  int            errors    = 0;
  int            tests_run = 0;
  // reference copy of the recording sequence number
  rr_seq_t       exp_seq;

  rr_wrapper DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // sink readies and monitor
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    i_cl_ready  = 1'b0;
    i_log_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      ready_rnd  = $urandom;
      i_cl_ready = cl_ready_rand ? ready_rnd[0] : 1'b1;
      case (log_ready_sel)
        0:       i_log_ready = 1'b0;
        1:       i_log_ready = 1'b1;
        default: i_log_ready = ready_rnd[1];
      endcase
    end
  end

  // a handshake sampled mid-cycle completes at the next edge
  always @(negedge clk) begin
    if (rstn) begin
      if (o_cl_valid && i_cl_ready) cl_q.push_back(o_cl_data);
      if (o_log_valid && i_log_ready) log_q.push_back(o_log_data);
      if (o_log_valid) log_valid_cnt++;
      if (o_sh_ready) sh_ready_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // driver tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic cfg_write(input rr_cfg_addr_t addr, input rr_cfg_data_t data);
    @(posedge clk);
    #1;
    i_cfg_valid = 1'b1;
    i_cfg_addr  = addr;
    i_cfg_wdata = data;
    @(posedge clk);
    #1;
    i_cfg_valid = 1'b0;
  endtask

  // holds until the chosen source sees ready and the transfer lands on the next edge
  task automatic await_ready(input bit rply);
    int waited = 0;
    bit done   = 1'b0;
    while (!done && waited < TIMEOUT) begin
      @(negedge clk);
      done = rply ? o_rply_ready : o_sh_ready;
      waited++;
    end
    if (!done) begin
      $display("source never granted ready within %0d cycles", TIMEOUT);
      errors++;
    end
  endtask

  task automatic send_sh(input rr_data_t data);
    @(posedge clk);
    #1;
    i_sh_valid = 1'b1;
    i_sh_data  = data;
    await_ready(1'b0);
    @(posedge clk);
    #1;
    i_sh_valid = 1'b0;
  endtask

  task automatic send_rply(input rr_data_t data);
    @(posedge clk);
    #1;
    i_rply_valid = 1'b1;
    i_rply_data  = data;
    await_ready(1'b1);
    @(posedge clk);
    #1;
    i_rply_valid = 1'b0;
  endtask

  task automatic pop_log(output rr_log_entry_t entry, output bit ok);
    int waited = 0;
    while (log_q.size() <= log_rd && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    ok = (log_q.size() > log_rd);
    if (ok) begin
      entry = log_q[log_rd];
      log_rd++;
    end else begin
      $display("no log entry arrived within %0d cycles", TIMEOUT);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checkers
  ////////////////////////////////////////////////////////////////////////////
  task automatic compare_cl(input int base, input rr_data_t exp_q[$]);
    if (cl_q.size() - base != exp_q.size()) begin
      $display("cl saw %0d transfers, expected %0d", cl_q.size() - base, exp_q.size());
      errors++;
    end else begin
      foreach (exp_q[i]) begin
        if (cl_q[base + i] !== exp_q[i]) begin
          $display("Fail o_cl_data: expected %h, got %h", exp_q[i], cl_q[base + i]);
          errors++;
        end
      end
    end
  endtask

  // log word is sequence number on top of the data
  task automatic expect_log(input rr_data_t data);
    rr_log_entry_t entry;
    bit            ok;
    pop_log(entry, ok);
    if (ok && entry !== {exp_seq, data}) begin
      $display("Fail o_log_data: expected %h, got %h", {exp_seq, data}, entry);
      errors++;
    end
    exp_seq++;
  endtask

  task automatic check_ovf(input logic exp);
    if (o_ovf !== exp) begin
      $display("Fail o_ovf: expected %h, got %h", exp, o_ovf);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - err0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic test_pass_through();
    int       err0 = errors;
    int       base = cl_q.size();
    int       lv0  = log_valid_cnt;
    rr_data_t exp_q[$];
    rr_data_t word;
    @(negedge clk);
    if (o_log_valid || o_ovf || o_rply_ready) begin
      $display("outputs not idle after reset");
      errors++;
    end
    cfg_write(`RR_ADDR_MODE, 32'd0);
    cl_ready_rand = 1'b1;
    for (int i = 0; i < 8; i++) begin
      word = $urandom;
      exp_q.push_back(word);
      send_sh(word);
    end
    repeat (2) @(negedge clk);
    compare_cl(base, exp_q);
    if (log_valid_cnt != lv0) begin
      $display("log stream went valid in pass-through mode");
      errors++;
    end
    report_test("pass_through", err0);
  endtask

  task automatic test_record();
    int       err0 = errors;
    int       base = cl_q.size();
    rr_data_t exp_q[$];
    rr_data_t word;
    cfg_write(`RR_ADDR_MODE, 32'd1);
    // record went from off to on
    exp_seq = '0;
    for (int i = 0; i < 6; i++) begin
      word = $urandom;
      exp_q.push_back(word);
      send_sh(word);
    end
    repeat (2) @(negedge clk);
    compare_cl(base, exp_q);
    foreach (exp_q[i]) expect_log(exp_q[i]);
    check_ovf(1'b0);
    report_test("record", err0);
  endtask

  task automatic test_replay();
    int       err0 = errors;
    int       base = cl_q.size();
    int       lv0  = log_valid_cnt;
    int       sh0;
    rr_data_t exp_q[$];
    rr_data_t word;
    cfg_write(`RR_ADDR_MODE, 32'd2);
    sh0 = sh_ready_cnt;
    // shell keeps offering a word that must never get through
    i_sh_valid = 1'b1;
    i_sh_data  = 32'hdead_beef;
    for (int i = 0; i < 5; i++) begin
      word = $urandom;
      exp_q.push_back(word);
      send_rply(word);
    end
    repeat (2) @(negedge clk);
    compare_cl(base, exp_q);
    if (sh_ready_cnt != sh0) begin
      $display("shell saw ready while replay was selected");
      errors++;
    end
    if (log_valid_cnt != lv0) begin
      $display("log entries appeared in replay mode");
      errors++;
    end
    @(posedge clk);
    #1;
    i_sh_valid = 1'b0;
    report_test("replay", err0);
  endtask

  task automatic test_replay_record();
    int       err0 = errors;
    int       base = cl_q.size();
    rr_data_t exp_q[$];
    rr_data_t word;
    cfg_write(`RR_ADDR_MODE, 32'd3);
    exp_seq       = '0;
    log_ready_sel = 2;
    for (int i = 0; i < 4; i++) begin
      word = $urandom;
      exp_q.push_back(word);
      send_rply(word);
    end
    repeat (2) @(negedge clk);
    compare_cl(base, exp_q);
    foreach (exp_q[i]) expect_log(exp_q[i]);
    log_ready_sel = 1;
    report_test("replay_record", err0);
  endtask

  task automatic test_overflow();
    int       err0 = errors;
    int       base;
    rr_data_t exp_q[$];
    rr_data_t word;
    log_ready_sel = 0;
    // pass mode first so the sequence restarts
    cfg_write(`RR_ADDR_MODE, 32'd0);
    cfg_write(`RR_ADDR_MODE, 32'd1);
    exp_seq = '0;
    base    = cl_q.size();
    for (int i = 0; i < 6; i++) begin
      word = $urandom;
      exp_q.push_back(word);
      send_sh(word);
    end
    repeat (2) @(negedge clk);
    compare_cl(base, exp_q);
    check_ovf(1'b1);
    log_ready_sel = 1;
    for (int i = 0; i < `RR_LOG_DEPTH; i++) expect_log(exp_q[i]);
    repeat (8) @(negedge clk);
    if (log_q.size() != log_rd || o_log_valid) begin
      $display("log fifo delivered more entries than it can hold");
      errors++;
    end
    cfg_write(`RR_ADDR_CLEAR, 32'd0);
    @(negedge clk);
    check_ovf(1'b0);
    report_test("overflow", err0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(32'h6742_e146));
    rstn          = 1'b0;
    i_cfg_valid   = 1'b0;
    i_cfg_addr    = '0;
    i_cfg_wdata   = '0;
    i_sh_valid    = 1'b0;
    i_sh_data     = '0;
    i_rply_valid  = 1'b0;
    i_rply_data   = '0;
    cl_ready_rand = 1'b0;
    log_ready_sel = 1;
    exp_seq       = '0;
    repeat (4) @(posedge clk);
    #1;
    rstn = 1'b1;
    test_pass_through();
    test_record();
    test_replay();
    test_replay_record();
    test_overflow();
    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+design
design/rr_bus_pkg.sv
design/rr_ctrl_pkg.sv
design/rr_csr_decode.sv
design/rr_channel_select.sv
design/rr_log_writeback.sv
design/rr_wrapper.sv
tests/tb_rr_wrapper.sv

//--- Makefile
# Verilator build and run for the record/replay wrapper

VERILATOR ?= verilator
TOP       ?= tb_rr_wrapper
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS    := $(wildcard design/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
